/* design/dct_defs.svh */
// DCT width definitions
`ifndef DCT_DEFS_SVH
`define DCT_DEFS_SVH

// ---------------------------------------------------------------------------
// Data path widths
// ---------------------------------------------------------------------------

// Raw pixel sample, unsigned
`define DCT_DW 8

// After the row pass: 8 + 3 for the 1-D sum, + 2 for the AAN gain
`define DCT_CW (`DCT_DW + 5)

// After the column pass, full size
`define DCT_C2W (`DCT_CW + 5)

`define DCT_QW (`DCT_DW + 7)    // Output coefficient, column pass >>> 3

// ---------------------------------------------------------------------------
`define DCT_KFRAC 8             // Fraction bits of the AAN multipliers

`endif

/* design/dct_pkg.sv */
// DCT coefficient arithmetic
`include "dct_defs.svh"

package dct_pkg;

    typedef logic signed [`DCT_CW-1:0]  mid_coef_t;   // Row pass result
    typedef logic signed [`DCT_C2W-1:0] wide_coef_t;  // Column pass result
    typedef logic signed [`DCT_QW-1:0]  q_coef_t;     // Narrowed output

    typedef mid_coef_t  [7:0] mid_vec_t;
    typedef wide_coef_t [7:0] wide_vec_t;
    typedef q_coef_t    [7:0] q_vec_t;

    // Internal butterfly width, two guard bits over the widest result
    typedef logic signed [`DCT_C2W+1:0]   aan_acc_t;
    typedef logic signed [`DCT_KFRAC+3:0] aan_k_t;

    // AAN multipliers, scaled by 2^KFRAC
    localparam aan_k_t aan_c1 = 181;   // cos(pi/4)
    localparam aan_k_t aan_c2 = 139;   // 0.541196
    localparam aan_k_t aan_c3 = 181;   // cos(pi/4), odd part
    localparam aan_k_t aan_c4 = 334;   // 1.306563
    localparam aan_k_t aan_c5 = 98;    // 0.382683

    // Constant multiply, floor shift back to integer scale
    function automatic aan_acc_t aan_mul(aan_acc_t x, aan_k_t k);
        logic signed [$bits(aan_acc_t)+$bits(aan_k_t)-1:0] p;
        p = x * k;
        return aan_acc_t'(p >>> `DCT_KFRAC);
    endfunction

endpackage

/* design/blk_pkg.sv */
// Block stream types
`include "dct_defs.svh"

package blk_pkg;

    typedef logic [2:0] row_idx_t;               // Row or column within a block

    typedef logic [`DCT_DW-1:0] pix_t;           // Unsigned sample
    typedef pix_t [7:0]         pix_vec_t;

    // ---------------------------------------------------------------------------
    // One beat per row, payload plus its index
    // ---------------------------------------------------------------------------
    typedef struct packed {
        pix_vec_t pix;
        row_idx_t idx;
    } pix_row_t;

    // Level-shifted rows and transpose reads
    typedef struct packed {
        dct_pkg::mid_vec_t vec;
        row_idx_t          idx;
    } mid_row_t;

    typedef struct packed {
        dct_pkg::wide_vec_t vec;                 // Engine output
        row_idx_t           idx;
    } wide_row_t;

    typedef struct packed {
        dct_pkg::q_vec_t vec;                    // Top level output
        row_idx_t        idx;
    } q_row_t;

endpackage

/* design/pixel_level_shift.sv */
// Pixel level shifter
`include "dct_defs.svh"

module pixel_level_shift import blk_pkg::*, dct_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  pix_row_t pix_in,
    input  logic     pix_valid,
    output logic     pix_hold,
    output mid_row_t shift_row,
    output logic     shift_valid,
    input  logic     shift_hold
);

    mid_vec_t shifted;       // Input row minus 128
    logic     load;          // Register free or draining this cycle

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            // Flipping the MSB subtracts 128
            shifted[i] = {{(`DCT_CW-`DCT_DW){~pix_in.pix[i][`DCT_DW-1]}},
                          ~pix_in.pix[i][`DCT_DW-1], pix_in.pix[i][`DCT_DW-2:0]};
        end
    end

    assign pix_hold = shift_valid & shift_hold;   // Full and stuck
    assign load     = ~pix_hold;

    always_ff @(posedge clk) begin
        if (!resetn)
            shift_valid <= 1'b0;
        else if (load)
            shift_valid <= pix_valid;
    end

    always_ff @(posedge clk) begin
        if (load && pix_valid) begin
            shift_row.vec <= shifted;
            shift_row.idx <= pix_in.idx;          // Index rides along untouched
        end
    end

    a_shift_stable : assert property (@(posedge clk) disable iff (!resetn)
        shift_valid && shift_hold |=> shift_valid && $stable(shift_row))
        else $error("shift_row changed while held");

endmodule

/* design/dct_1d_aan.sv */
// AAN 8-point DCT engine
`include "dct_defs.svh"

module dct_1d_aan import dct_pkg::*, blk_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  mid_row_t  in_row,
    input  logic      in_valid,
    output logic      in_hold,
    output wide_row_t out_row,
    output logic      out_valid,
    input  logic      out_hold
);

    logic     adv;                   // Whole pipe moves
    aan_acc_t x [8];                 // Sign-extended input

    // Stage 1 regs
    aan_acc_t s1_sum [4];            // tmp0..tmp3
    aan_acc_t s1_dif [4];            // tmp7, tmp6, tmp5, tmp4
    row_idx_t s1_idx;
    logic     s1_valid;

    // Stage 2 regs
    aan_acc_t s2_e10, s2_e11, s2_e13, s2_e1213;
    aan_acc_t s2_o10, s2_o11, s2_o12, s2_o512, s2_o7;
    row_idx_t s2_idx;
    logic     s2_valid;

    // Stage 3 regs
    aan_acc_t s3_y0, s3_y4, s3_e13, s3_z1;
    aan_acc_t s3_z3, s3_z5, s3_m2, s3_m4, s3_o7;
    row_idx_t s3_idx;
    logic     s3_valid;

    aan_acc_t z2, z4, z11, z13;      // Odd part tail
    aan_acc_t y [8];                 // Final butterflies, natural order

    // Stall only when a finished row cannot leave
    assign adv     = ~(out_valid & out_hold);
    assign in_hold = ~adv;

    always_comb begin
        for (int i = 0; i < 8; i++)
            x[i] = aan_acc_t'(in_row.vec[i]);
    end

    // ---------------------------------------------------------------------------
    // Valid chain
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (adv) begin
            s1_valid  <= in_valid;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            out_valid <= s3_valid;
        end
    end

    // ---------------------------------------------------------------------------
    // Data stages
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (adv) begin
            // Stage 1, mirrored sums and differences
            for (int k = 0; k < 4; k++) begin
                s1_sum[k] <= x[k] + x[7-k];
                s1_dif[k] <= x[k] - x[7-k];
            end
            s1_idx <= in_row.idx;

            // Stage 2, even butterflies
            s2_e10   <= s1_sum[0] + s1_sum[3];
            s2_e11   <= s1_sum[1] + s1_sum[2];
            s2_e13   <= s1_sum[0] - s1_sum[3];
            s2_e1213 <= (s1_sum[1] - s1_sum[2]) + (s1_sum[0] - s1_sum[3]);
            // Odd butterflies
            s2_o10   <= s1_dif[3] + s1_dif[2];                // tmp4 + tmp5
            s2_o11   <= s1_dif[2] + s1_dif[1];                // tmp5 + tmp6
            s2_o12   <= s1_dif[1] + s1_dif[0];                // tmp6 + tmp7
            s2_o512  <= (s1_dif[3] + s1_dif[2]) - (s1_dif[1] + s1_dif[0]);
            s2_o7    <= s1_dif[0];
            s2_idx   <= s1_idx;

            // Stage 3, constant multiplies
            s3_y0  <= s2_e10 + s2_e11;
            s3_y4  <= s2_e10 - s2_e11;
            s3_e13 <= s2_e13;
            s3_z1  <= aan_mul(s2_e1213, aan_c1);
            s3_m2  <= aan_mul(s2_o10, aan_c2);
            s3_z3  <= aan_mul(s2_o11, aan_c3);
            s3_m4  <= aan_mul(s2_o12, aan_c4);
            s3_z5  <= aan_mul(s2_o512, aan_c5);
            s3_o7  <= s2_o7;
            s3_idx <= s2_idx;

            // Stage 4, truncate to output width
            for (int i = 0; i < 8; i++)
                out_row.vec[i] <= y[i][`DCT_C2W-1:0];
            out_row.idx <= s3_idx;
        end
    end

    always_comb begin
        z2   = s3_m2 + s3_z5;
        z4   = s3_m4 + s3_z5;
        z11  = s3_o7 + s3_z3;
        z13  = s3_o7 - s3_z3;
        y[0] = s3_y0;
        y[1] = z11 + z4;
        y[2] = s3_e13 + s3_z1;
        y[3] = z13 - z2;
        y[4] = s3_y4;
        y[5] = z13 + z2;
        y[6] = s3_e13 - s3_z1;
        y[7] = z11 - z4;
    end

    a_out_stable : assert property (@(posedge clk) disable iff (!resetn)
        out_valid && out_hold |=> out_valid && $stable(out_row))
        else $error("out_row changed while held");

    a_valid_known : assert property (@(posedge clk) disable iff (!resetn)
        !$isunknown(out_valid))
        else $error("out_valid unknown after reset");

endmodule

/* design/dct_2d.sv */
// Shared-engine 2-D DCT
`include "dct_defs.svh"

module dct_2d import dct_pkg::*, blk_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  mid_row_t in_row,
    input  logic     in_valid,
    output logic     in_hold,
    output q_row_t   q_out,
    output logic     q_valid,
    input  logic     q_hold
);

    logic      src_sel;              // 0 input rows, 1 transpose reads
    logic      dest_sel;             // 1 transpose memory, 0 q_out
    logic      rd_phase;             // Column reads in progress
    row_idx_t  rd_col;
    mid_row_t  rd_row;
    mid_row_t  eng_in;
    logic      eng_in_valid;
    logic      eng_in_hold;
    wide_row_t eng_out;
    logic      eng_out_valid;
    logic      eng_out_hold;
    logic      wr_en;
    wide_vec_t tr_mem [8];           // Row-major with one row per word

    // ---------------------------------------------------------------------------
    // Engine source
    // ---------------------------------------------------------------------------
    assign in_hold      = src_sel | eng_in_hold;     // Input blocked on column pass
    assign eng_in_valid = src_sel ? rd_phase : in_valid;
    assign eng_in       = src_sel ? rd_row : in_row;

    always_ff @(posedge clk) begin
        if (!resetn)
            src_sel <= 1'b0;
        else if (eng_in_valid && !eng_in_hold && eng_in.idx == 3'd7)
            src_sel <= ~src_sel;
    end

    dct_1d_aan u_engine (
        .clk       (clk),
        .resetn    (resetn),
        .in_row    (eng_in),
        .in_valid  (eng_in_valid),
        .in_hold   (eng_in_hold),
        .out_row   (eng_out),
        .out_valid (eng_out_valid),
        .out_hold  (eng_out_hold)
    );

    // ---------------------------------------------------------------------------
    // Engine destination
    // ---------------------------------------------------------------------------
    assign eng_out_hold = dest_sel ? rd_phase : q_hold;
    assign wr_en        = dest_sel & eng_out_valid & ~eng_out_hold;
    assign q_valid      = ~dest_sel & eng_out_valid;

    always_comb begin
        for (int j = 0; j < 8; j++)
            q_out.vec[j] = eng_out.vec[j][`DCT_C2W-1:3];   // Arithmetic >>> 3
        q_out.idx = eng_out.idx;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            dest_sel <= 1'b1;
        else if (eng_out_valid && !eng_out_hold && eng_out.idx == 3'd7)
            dest_sel <= ~dest_sel;
    end

    // ---------------------------------------------------------------------------
    // Transpose memory
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en)
            tr_mem[eng_out.idx] <= eng_out.vec;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_phase <= 1'b0;
            rd_col   <= '0;
        end else if (rd_phase && !eng_in_hold) begin
            rd_col <= rd_col + 3'd1;                    // Wraps back to 0
            if (rd_col == 3'd7)
                rd_phase <= 1'b0;
        end else if (wr_en && eng_out.idx == 3'd7) begin
            rd_phase <= 1'b1;                           // Last row is in
        end
    end

    // Column read of row pass values that fit DCT_CW
    always_comb begin
        for (int j = 0; j < 8; j++)
            rd_row.vec[j] = tr_mem[j][rd_col][`DCT_CW-1:0];
        rd_row.idx = rd_col;
    end

    a_no_wr_in_rd : assert property (@(posedge clk) disable iff (!resetn)
        rd_phase |-> !(dest_sel && eng_out_valid))
        else $error("transpose write during read phase");

    // Rises on input row 7 and falls with the last column read
    a_src_toggle : assert property (@(posedge clk) disable iff (!resetn)
        $changed(src_sel) |-> $past(src_sel ? rd_col : in_row.idx) == 3'd7
                              && $fell(src_sel) == $fell(rd_phase))
        else $error("source select toggled off index 7");

endmodule

/* design/jpeg_dct_top.sv */
// JPEG forward DCT top level
module jpeg_dct_top import blk_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  pix_row_t pix_in,
    input  logic     pix_valid,
    output logic     pix_hold,
    output q_row_t   q_out,
    output logic     q_valid,
    input  logic     q_hold
);

    mid_row_t shift_row;             // Level-shifted row into the DCT
    logic     shift_valid;
    logic     shift_hold;

    pixel_level_shift u_shift (
        .clk         (clk),
        .resetn      (resetn),
        .pix_in      (pix_in),
        .pix_valid   (pix_valid),
        .pix_hold    (pix_hold),
        .shift_row   (shift_row),
        .shift_valid (shift_valid),
        .shift_hold  (shift_hold)
    );

    dct_2d u_dct (
        .clk      (clk),
        .resetn   (resetn),
        .in_row   (shift_row),
        .in_valid (shift_valid),
        .in_hold  (shift_hold),
        .q_out    (q_out),
        .q_valid  (q_valid),
        .q_hold   (q_hold)
    );

endmodule

/* testbench/tb_dct_model.sv */
// DCT reference model
`include "dct_defs.svh"

package tb_dct_model;

    import dct_pkg::*;
    import blk_pkg::*;

    // AAN constants, scaled by 2^KFRAC
    localparam longint k_c1 = 181;
    localparam longint k_c2 = 139;
    localparam longint k_c3 = 181;
    localparam longint k_c4 = 334;
    localparam longint k_c5 = 98;

    // Keep the low w bits, sign-extended
    function automatic longint sign_wrap(input longint v, input int w);
        return (v << (64 - w)) >>> (64 - w);
    endfunction

    function automatic longint const_mul(input longint a, input longint k);
        return (a * k) >>> `DCT_KFRAC;              // Floor toward minus infinity
    endfunction

    // ---------------------------------------------------------------------------
    // One 8-point AAN pass, outputs left scaled
    // ---------------------------------------------------------------------------
    function automatic void aan_1d(input longint x [8], output longint y [8]);
        longint t0, t1, t2, t3, t4, t5, t6, t7;
        longint p10, p11, p12, p13;
        longint z1, z2, z3, z4, z5, z11, z13;
        t0 = x[0] + x[7];
        t7 = x[0] - x[7];
        t1 = x[1] + x[6];
        t6 = x[1] - x[6];
        t2 = x[2] + x[5];
        t5 = x[2] - x[5];
        t3 = x[3] + x[4];
        t4 = x[3] - x[4];
        // Even half
        p10 = t0 + t3;
        p13 = t0 - t3;
        p11 = t1 + t2;
        p12 = t1 - t2;
        y[0] = p10 + p11;
        y[4] = p10 - p11;
        z1   = const_mul(p12 + p13, k_c1);
        y[2] = p13 + z1;
        y[6] = p13 - z1;
        // Odd half
        p10 = t4 + t5;
        p11 = t5 + t6;
        p12 = t6 + t7;
        z5  = const_mul(p10 - p12, k_c5);
        z2  = const_mul(p10, k_c2) + z5;
        z4  = const_mul(p12, k_c4) + z5;
        z3  = const_mul(p11, k_c3);
        z11 = t7 + z3;
        z13 = t7 - z3;
        y[5] = z13 + z2;
        y[3] = z13 - z2;
        y[1] = z11 + z4;
        y[7] = z11 - z4;
    endfunction

    // Whole block, rows then columns, one result per column
    function automatic void dct_block(input pix_vec_t rows [8], output q_row_t res [8]);
        longint v [8];
        longint y [8];
        longint mid [8][8];
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++)
                v[c] = longint'(rows[r][c]) - 128;     // Level shift
            aan_1d(v, y);
            for (int c = 0; c < 8; c++)
                mid[r][c] = sign_wrap(y[c], `DCT_CW);
        end
        for (int c = 0; c < 8; c++) begin
            for (int r = 0; r < 8; r++)
                v[r] = mid[r][c];
            aan_1d(v, y);
            res[c].idx = 3'(c);
            for (int k = 0; k < 8; k++)
                res[c].vec[k] = q_coef_t'(sign_wrap(y[k], `DCT_C2W) >>> 3);
        end
    endfunction

endpackage

/* testbench/tb_jpeg_dct.sv */
// Forward DCT testbench
module tb_jpeg_dct import tb_dct_model::*, blk_pkg::*, dct_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NBLK      = 40;
    localparam int NBEAT     = NBLK * 8;       // Output columns expected
    localparam int GAP_FROM  = 13;             // pix_valid gaps from this block on
    localparam int HOLD_FROM = 26;             // Random q_hold from this block on

    logic     clk;
    logic     resetn;
    pix_row_t pix_in;
    logic     pix_valid;
    logic     pix_hold;
    q_row_t   q_out;
    logic     q_valid;
    logic     q_hold;

    logic [31:0] lfsr = 32'ha6824878;
    pix_vec_t    blocks [NBLK][8];
    q_row_t      exp_rows [NBEAT];             // Model output in arrival order
    q_row_t      exp_head;
    int          rx_cnt;
    int          rows_in;                      // Rows taken at the input
    logic        started;                      // First row driven
    logic        held_prev;
    q_row_t      q_prev;

    jpeg_dct_top i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .pix_in    (pix_in),
        .pix_valid (pix_valid),
        .pix_hold  (pix_hold),
        .q_out     (q_out),
        .q_valid   (q_valid),
        .q_hold    (q_hold)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                      // 8 ns period

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] draw_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    // ---------------------------------------------------------------------------
    // Bookkeeping and checks
    // ---------------------------------------------------------------------------
    assign exp_head = exp_rows[rx_cnt];

    always @(posedge clk) begin
        if (!resetn) begin
            rx_cnt    <= 0;
            rows_in   <= 0;
            held_prev <= 1'b0;
        end else begin
            if (q_valid && !q_hold)
                rx_cnt <= rx_cnt + 1;
            if (pix_valid && !pix_hold)
                rows_in <= rows_in + 1;
            held_prev <= q_valid && q_hold;
        end
        q_prev <= q_out;
    end

    a_idle : assert property (@(posedge clk) disable iff (!resetn)
        !started |-> !q_valid && !pix_hold)
        else report_fail("q_valid or pix_hold went high before any input");

    a_match : assert property (@(posedge clk) disable iff (!resetn)
        q_valid && !q_hold && rx_cnt < NBEAT |-> q_out == exp_head)
        else report_fail($sformatf("mismatch q_out: got %h, expected %h",
                                   $sampled(q_out), $sampled(exp_head)));

    a_extra : assert property (@(posedge clk) disable iff (!resetn)
        q_valid && !q_hold |-> rx_cnt < NBEAT)
        else report_fail("q_out delivered more columns than were sent");

    // Flat blocks give a nonzero DC term in column 0 only
    a_dc_only : assert property (@(posedge clk) disable iff (!resetn)
        q_valid && !q_hold && rx_cnt < 16 |->
            ((q_out.idx == 3'd0) ? (q_out.vec[7:1] == '0) : (q_out.vec == '0)))
        else report_fail($sformatf("mismatch q_out.vec of flat block: %h",
                                   $sampled(q_out.vec)));

    a_held : assert property (@(posedge clk) disable iff (!resetn)
        held_prev |-> q_valid && q_out == q_prev)
        else report_fail($sformatf("mismatch q_out under hold: was %h, now %h, q_valid %h",
                                   $sampled(q_prev), $sampled(q_out), $sampled(q_valid)));

    // Column 0 of a block leaves with at most one row of the next block taken
    a_in_blocked : assert property (@(posedge clk) disable iff (!resetn)
        q_valid && !q_hold && q_out.idx == 3'd0 |-> rows_in <= rx_cnt + 9)
        else report_fail("input kept taking rows during the column pass");

    // ---------------------------------------------------------------------------
    // Stimulus
    // ---------------------------------------------------------------------------
    initial begin
        pix_vec_t blk [8];
        q_row_t   cols [8];
        int       b;
        int       r;
        resetn    = 1'b0;
        pix_in    = '0;
        pix_valid = 1'b0;
        q_hold    = 1'b0;
        started   = 1'b0;
        // Two flat blocks and random ones with a gapped replay of the first 13
        for (int i = 0; i < NBLK; i++) begin
            for (int j = 0; j < 8; j++) begin
                for (int k = 0; k < 8; k++) begin
                    if (i < 2)
                        blk[j][k] = (i == 0) ? 8'd200 : 8'd37;
                    else if (i >= GAP_FROM && i < 2 * GAP_FROM)
                        blk[j][k] = blocks[i - GAP_FROM][j][k];
                    else
                        blk[j][k] = 8'(draw_bits(8));
                end
                blocks[i][j] = blk[j];
            end
            dct_block(blk, cols);
            for (int c = 0; c < 8; c++)
                exp_rows[i * 8 + c] = cols[c];
        end
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        repeat (4) @(posedge clk);             // Idle window for a_idle
        b = 0;
        r = 0;
        while (rx_cnt < NBEAT) begin
            if (pix_valid && !pix_hold) begin  // Row taken on this edge
                if (r == 7) begin
                    r = 0;
                    b++;
                end else begin
                    r++;
                end
            end
            if (!(pix_valid && pix_hold)) begin
                if (b < NBLK && (b < GAP_FROM || draw_bits(2) != 0)) begin
                    pix_in.pix <= blocks[b][r];
                    pix_in.idx <= 3'(r);
                    pix_valid  <= 1'b1;
                    started    <= 1'b1;
                end else begin
                    pix_valid <= 1'b0;
                end
            end
            q_hold <= (b >= HOLD_FROM) && draw_bits(1) == 1;
            @(posedge clk);
        end
        q_hold <= 1'b0;                        // A stray beat gets taken
        repeat (20) @(posedge clk);            // Room for a stray extra beat
        if (rx_cnt == NBEAT && b == NBLK) begin
            $display("test passed");
            $finish;
        end else begin
            report_fail("column count does not match the blocks sent");
        end
    end

    // Watchdog
    initial begin
        #(NBLK * 64 * 4 * 8);
        report_fail("timeout waiting for q_out columns");
    end

endmodule

/* jpeg_dct.f */
+incdir+design
design/dct_pkg.sv
design/blk_pkg.sv
design/pixel_level_shift.sv
design/dct_1d_aan.sv
design/dct_2d.sv
design/jpeg_dct_top.sv
testbench/tb_dct_model.sv
testbench/tb_jpeg_dct.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the forward DCT testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_jpeg_dct -f jpeg_dct.f \
    && ./obj_dir/Vtb_jpeg_dct 2>&1 | tee sim.log \
    || { echo "build or simulation stopped with an error"; exit 1; }

grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
